//--- include/fpu_consts.svh
`ifndef FPU_CONSTS_SVH
`define FPU_CONSTS_SVH

// APB register map, byte addresses on a 5-bit paddr
`define FPU_ADDR_OPA      5'h00
`define FPU_ADDR_OPB      5'h04
`define FPU_ADDR_CTRL     5'h08
`define FPU_ADDR_RESULT   5'h0C
`define FPU_ADDR_STATUS   5'h10

// CTRL fields
`define FPU_CTRL_GO_BIT   0
`define FPU_CTRL_OP_BIT   1

// STATUS fields, all write-1-to-clear
`define FPU_STAT_DONE_BIT 0
`define FPU_STAT_OVF_BIT  1
`define FPU_STAT_UNF_BIT  2
`define FPU_STAT_NAN_BIT  3

// canonical quiet NaN for every invalid result
`define FPU_QNAN          32'h7FFF_FFFF
`define FPU_EXP_MAX       8'hFF

`endif

//--- design/fpu_pkg.sv
package fpu_pkg;

    // operation select, taken from the CTRL op bit
    typedef enum logic {
        FP_ADD = 1'b0,
        FP_SUB = 1'b1
    } fp_op_e;

    // decoded APB register
    typedef enum logic [2:0] {
        REG_OPA    = 3'd0,
        REG_OPB    = 3'd1,
        REG_CTRL   = 3'd2,
        REG_RESULT = 3'd3,
        REG_STATUS = 3'd4,
        REG_NONE   = 3'd7
    } reg_sel_e;

endpackage

//--- design/fp_adder_subtractor.sv
`timescale 1ns/1ns
`include "fpu_consts.svh"

module fp_adder_subtractor (
    input  logic [31:0]     operand1,
    input  logic [31:0]     operand2,
    input  fpu_pkg::fp_op_e operation,
    output logic [31:0]     result,
    output logic            overflow,
    output logic            underflow,
    output logic            invalid
);

    logic        sign_a;
    logic        sign_b;
    logic [7:0]  exp_a;
    logic [7:0]  exp_b;
    logic        nan_a;
    logic        nan_b;
    logic        inf_a;
    logic        inf_b;
    logic        zero_a;
    logic        zero_b;
    logic        any_normal;
    logic        a_is_big;
    logic [30:0] big_mag;
    logic [30:0] small_mag;
    logic        big_sign;
    logic        eff_sub;
    logic [7:0]  big_exp;
    logic [7:0]  small_exp;
    logic [23:0] big_sig;
    logic [23:0] small_sig;
    logic [7:0]  exp_diff;
    logic [23:0] small_sh;
    logic [24:0] sum;
    logic [4:0]  lz;
    logic [8:0]  exp_up;
    logic [23:0] norm_sig;
    logic [23:0] sub_sig;

    function automatic logic [4:0] lzc24(input logic [23:0] v);
        logic [4:0] n;
        logic       hit;
        n   = 5'd0;
        hit = 1'b0;
        for (int i = 23; i >= 0; i--) begin
            if (!hit && !v[i]) begin
                n = n + 5'd1;
            end else begin
                hit = 1'b1;
            end
        end
        return n;
    endfunction

    // sub flips the sign of operand2 so the rest only ever adds
    assign sign_a = operand1[31];
    assign sign_b = operand2[31] ^ (operation == fpu_pkg::FP_SUB);
    assign exp_a  = operand1[30:23];
    assign exp_b  = operand2[30:23];

    assign nan_a  = (exp_a == `FPU_EXP_MAX) && (operand1[22:0] != 23'd0);
    assign nan_b  = (exp_b == `FPU_EXP_MAX) && (operand2[22:0] != 23'd0);
    assign inf_a  = (exp_a == `FPU_EXP_MAX) && (operand1[22:0] == 23'd0);
    assign inf_b  = (exp_b == `FPU_EXP_MAX) && (operand2[22:0] == 23'd0);
    assign zero_a = (operand1[30:0] == 31'd0);
    assign zero_b = (operand2[30:0] == 31'd0);
    assign any_normal = (exp_a != 8'd0) || (exp_b != 8'd0);

    // magnitude order, so the difference below never goes negative
    assign a_is_big  = (operand1[30:0] >= operand2[30:0]);
    assign big_mag   = a_is_big ? operand1[30:0] : operand2[30:0];
    assign small_mag = a_is_big ? operand2[30:0] : operand1[30:0];
    assign big_sign  = a_is_big ? sign_a : sign_b;
    assign eff_sub   = sign_a ^ sign_b;

    // subnormals sit at exponent 1 without the hidden bit
    assign big_exp   = (big_mag[30:23] == 8'd0) ? 8'd1 : big_mag[30:23];
    assign small_exp = (small_mag[30:23] == 8'd0) ? 8'd1 : small_mag[30:23];
    assign big_sig   = {big_mag[30:23] != 8'd0, big_mag[22:0]};
    assign small_sig = {small_mag[30:23] != 8'd0, small_mag[22:0]};

    assign exp_diff = big_exp - small_exp;
    assign small_sh = small_sig >> exp_diff;
    assign sum      = eff_sub ? ({1'b0, big_sig} - {1'b0, small_sh})
                              : ({1'b0, big_sig} + {1'b0, small_sh});

    assign lz       = lzc24(sum[23:0]);
    assign exp_up   = {1'b0, big_exp} + 9'd1;
    assign norm_sig = sum[23:0] << lz;
    // shift only as far as exponent 1 allows
    assign sub_sig  = sum[23:0] << (big_exp - 8'd1);

    always_comb begin
        result    = 32'd0;
        overflow  = 1'b0;
        underflow = 1'b0;
        invalid   = 1'b0;
        if (nan_a || nan_b) begin
            result  = `FPU_QNAN;
            invalid = 1'b1;
        end else if (inf_a && inf_b && eff_sub) begin
            result  = `FPU_QNAN;
            invalid = 1'b1;
        end else if (inf_a) begin
            result = {sign_a, `FPU_EXP_MAX, 23'd0};
        end else if (inf_b) begin
            result = {sign_b, `FPU_EXP_MAX, 23'd0};
        end else if (zero_a && zero_b) begin
            result = {sign_a & sign_b, 31'd0};
        end else if (zero_a) begin
            result = {sign_b, operand2[30:0]};
        end else if (zero_b) begin
            result = operand1;
        end else if (exp_diff > 8'd23) begin
            // smaller operand lost entirely in the alignment shift
            result = {big_sign, big_mag};
        end else if (sum == 25'd0) begin
            result = 32'd0;
        end else if (sum[24]) begin
            if (exp_up > 9'd254) begin
                overflow = 1'b1;
                result   = {big_sign, `FPU_EXP_MAX, 23'd0};
            end else begin
                result = {big_sign, exp_up[7:0], sum[23:1]};
            end
        end else if ({3'd0, lz} < big_exp) begin
            result = {big_sign, big_exp - {3'd0, lz}, norm_sig[22:0]};
        end else begin
            result    = {big_sign, 8'd0, sub_sig[22:0]};
            underflow = any_normal;
        end
    end

    // every NaN leaving the core is the canonical one
    a_qnan_only: assert final (!((result[30:23] == `FPU_EXP_MAX) && (result[22:0] != 23'd0))
                               || (result == `FPU_QNAN));

endmodule

//--- design/fpu_exec.sv
`timescale 1ns/1ns
`include "fpu_consts.svh"

module fpu_exec (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            start,
    input  logic [31:0]     op_a,
    input  logic [31:0]     op_b,
    input  fpu_pkg::fp_op_e op,
    input  logic [3:0]      clr_flags,
    output logic            busy,
    output logic            done,
    output logic [31:0]     result,
    output logic            ovf_flag,
    output logic            unf_flag,
    output logic            nan_flag
);

    logic            s1_valid;
    logic [31:0]     s1_a;
    logic [31:0]     s1_b;
    fpu_pkg::fp_op_e s1_op;
    logic [31:0]     core_result;
    logic            core_ovf;
    logic            core_unf;
    logic            core_nan;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= start;
        end
    end

    // stage 1 operands feed the core directly
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_a  <= 32'd0;
            s1_b  <= 32'd0;
            s1_op <= fpu_pkg::FP_ADD;
        end else if (start) begin
            s1_a  <= op_a;
            s1_b  <= op_b;
            s1_op <= op;
        end
    end

    fp_adder_subtractor core (
        .operand1  (s1_a),
        .operand2  (s1_b),
        .operation (s1_op),
        .result    (core_result),
        .overflow  (core_ovf),
        .underflow (core_unf),
        .invalid   (core_nan)
    );

    // stage 2, flags accumulate until software clears them
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result   <= 32'd0;
            done     <= 1'b0;
            ovf_flag <= 1'b0;
            unf_flag <= 1'b0;
            nan_flag <= 1'b0;
        end else begin
            if (s1_valid) begin
                result <= core_result;
                done   <= 1'b1;
            end else if (start || clr_flags[`FPU_STAT_DONE_BIT]) begin
                done <= 1'b0;
            end
            ovf_flag <= (ovf_flag && !clr_flags[`FPU_STAT_OVF_BIT]) || (s1_valid && core_ovf);
            unf_flag <= (unf_flag && !clr_flags[`FPU_STAT_UNF_BIT]) || (s1_valid && core_unf);
            nan_flag <= (nan_flag && !clr_flags[`FPU_STAT_NAN_BIT]) || (s1_valid && core_nan);
        end
    end

    assign busy = start || s1_valid;

    a_no_start_busy: assert property (@(posedge clk) disable iff (!arst_n)
        start |-> !$past(busy));
    a_done_latency: assert property (@(posedge clk) disable iff (!arst_n)
        start |-> ##2 $rose(done));

endmodule

//--- design/fpu_apb_regs.sv
`timescale 1ns/1ns
`include "fpu_consts.svh"

module fpu_apb_regs (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            psel,
    input  logic            penable,
    input  logic            pwrite,
    input  logic [4:0]      paddr,
    input  logic [31:0]     pwdata,
    output logic [31:0]     prdata,
    output logic            pready,
    output logic            pslverr,
    output logic [31:0]     op_a,
    output logic [31:0]     op_b,
    output fpu_pkg::fp_op_e op,
    output logic            start,
    output logic [3:0]      clr_flags,
    input  logic            busy,
    input  logic            done,
    input  logic [31:0]     result,
    input  logic            ovf_flag,
    input  logic            unf_flag,
    input  logic            nan_flag
);

    fpu_pkg::reg_sel_e sel;
    logic              access;
    logic              go_req;
    logic              bad_access;
    logic              wr_en;
    logic [31:0]       ctrl_rd;
    logic [31:0]       status_rd;

    always_comb begin
        case (paddr)
            `FPU_ADDR_OPA:    sel = fpu_pkg::REG_OPA;
            `FPU_ADDR_OPB:    sel = fpu_pkg::REG_OPB;
            `FPU_ADDR_CTRL:   sel = fpu_pkg::REG_CTRL;
            `FPU_ADDR_RESULT: sel = fpu_pkg::REG_RESULT;
            `FPU_ADDR_STATUS: sel = fpu_pkg::REG_STATUS;
            default:          sel = fpu_pkg::REG_NONE;
        endcase
    end

    assign access = psel && penable;
    assign go_req = pwrite && (sel == fpu_pkg::REG_CTRL) && pwdata[`FPU_CTRL_GO_BIT];

    // unmapped, write to read-only RESULT, or go while an op is in flight
    assign bad_access = (sel == fpu_pkg::REG_NONE)
                     || (pwrite && (sel == fpu_pkg::REG_RESULT))
                     || (go_req && busy);

    // zero wait states
    assign pready  = 1'b1;
    assign pslverr = access && bad_access;
    assign wr_en   = access && pwrite && !bad_access;

    // W1C pulses land on the same edge as the write
    assign clr_flags = (wr_en && (sel == fpu_pkg::REG_STATUS)) ? pwdata[3:0] : 4'd0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            op_a  <= 32'd0;
            op_b  <= 32'd0;
            op    <= fpu_pkg::FP_ADD;
            start <= 1'b0;
        end else begin
            start <= wr_en && go_req;
            if (wr_en && (sel == fpu_pkg::REG_OPA)) begin
                op_a <= pwdata;
            end
            if (wr_en && (sel == fpu_pkg::REG_OPB)) begin
                op_b <= pwdata;
            end
            if (wr_en && (sel == fpu_pkg::REG_CTRL)) begin
                op <= fpu_pkg::fp_op_e'(pwdata[`FPU_CTRL_OP_BIT]);
            end
        end
    end

    always_comb begin
        ctrl_rd                              = 32'd0;
        ctrl_rd[`FPU_CTRL_OP_BIT]            = op;
        status_rd                            = 32'd0;
        status_rd[`FPU_STAT_DONE_BIT]        = done;
        status_rd[`FPU_STAT_OVF_BIT]         = ovf_flag;
        status_rd[`FPU_STAT_UNF_BIT]         = unf_flag;
        status_rd[`FPU_STAT_NAN_BIT]         = nan_flag;
    end

    always_comb begin
        case (sel)
            fpu_pkg::REG_OPA:    prdata = op_a;
            fpu_pkg::REG_OPB:    prdata = op_b;
            fpu_pkg::REG_CTRL:   prdata = ctrl_rd;
            fpu_pkg::REG_RESULT: prdata = result;
            fpu_pkg::REG_STATUS: prdata = status_rd;
            default:             prdata = 32'd0;
        endcase
    end

    // master side of the APB handshake
    a_penable_psel: assert property (@(posedge clk) disable iff (!arst_n)
        penable |-> psel);
    a_paddr_stable: assert property (@(posedge clk) disable iff (!arst_n)
        (psel && !penable) ##1 penable |-> $stable(paddr));

endmodule

//--- design/fpu_apb_top.sv
`timescale 1ns/1ns

module fpu_apb_top (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [4:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);

    logic [31:0]     op_a;
    logic [31:0]     op_b;
    fpu_pkg::fp_op_e op;
    logic            start;
    logic [3:0]      clr_flags;
    logic            busy;
    logic            done;
    logic [31:0]     result;
    logic            ovf_flag;
    logic            unf_flag;
    logic            nan_flag;

    fpu_apb_regs regs (
        .clk       (clk),
        .arst_n    (arst_n),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .op_a      (op_a),
        .op_b      (op_b),
        .op        (op),
        .start     (start),
        .clr_flags (clr_flags),
        .busy      (busy),
        .done      (done),
        .result    (result),
        .ovf_flag  (ovf_flag),
        .unf_flag  (unf_flag),
        .nan_flag  (nan_flag)
    );

    fpu_exec exec (
        .clk       (clk),
        .arst_n    (arst_n),
        .start     (start),
        .op_a      (op_a),
        .op_b      (op_b),
        .op        (op),
        .clr_flags (clr_flags),
        .busy      (busy),
        .done      (done),
        .result    (result),
        .ovf_flag  (ovf_flag),
        .unf_flag  (unf_flag),
        .nan_flag  (nan_flag)
    );

endmodule

//--- sim/tb_fpu.sv
`timescale 1ns/1ns
`include "fpu_consts.svh"

module tb_fpu;

    localparam int CLK_PERIOD    = 20;
    localparam int OPS_BUDGET    = 40;
    localparam int CYCLES_PER_OP = 12;
    // margin covers reset, special values and bus error transfers
    localparam int WATCHDOG_NS   = OPS_BUDGET * CYCLES_PER_OP * CLK_PERIOD + 10000;
    localparam int DONE_LIMIT    = 10;

    logic        clk;
    logic        arst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [4:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    // expectations sampled by the assertions
    logic        rd_check;
    logic [31:0] exp_rdata;
    logic        exp_err;

    logic [31:0] rng_state;
    logic [31:0] last_result;
    int          ia;
    int          ib;
    shortreal    ra;
    shortreal    rb;
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          test_start_errors;
    string       test_name;

    fpu_apb_top uut (
        .clk     (clk),
        .arst_n  (arst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    rdata_matches: assert property (@(posedge clk) disable iff (!arst_n)
        (psel && penable && !pwrite && rd_check) |-> (prdata == exp_rdata))
    else begin
        errors++;
        $display("FAIL prdata at addr %h: expected %h, got %h",
                 $sampled(paddr), $sampled(exp_rdata), $sampled(prdata));
    end

    slverr_matches: assert property (@(posedge clk) disable iff (!arst_n)
        (psel && penable) |-> (pslverr == exp_err))
    else begin
        errors++;
        $display("FAIL pslverr at addr %h: expected %h, got %h",
                 $sampled(paddr), $sampled(exp_err), $sampled(pslverr));
    end

    // zero wait states, every access phase completes at once
    pready_high: assert property (@(posedge clk) disable iff (!arst_n)
        (psel && penable) |-> pready)
    else begin
        errors++;
        $display("FAIL pready at addr %h: expected 1, got %h",
                 $sampled(paddr), $sampled(pready));
    end

    // done rises at the second edge after the accepted go write edge
    done_follows_go: assert property (@(posedge clk) disable iff (!arst_n)
        (psel && penable && pwrite && (paddr == `FPU_ADDR_CTRL)
         && pwdata[`FPU_CTRL_GO_BIT] && !exp_err) |-> ##3 $rose(uut.done))
    else begin
        errors++;
        $display("FAIL done: expected a rise 2 cycles after go, got %h", $sampled(uut.done));
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // integers in -1000..1000, small enough that every sum is exact
    function automatic int small_int(input logic [31:0] r);
        return int'(r % 32'd2001) - 1000;
    endfunction

    function automatic logic [4:0] reg_addr(input fpu_pkg::reg_sel_e r);
        case (r)
            fpu_pkg::REG_OPA:    return `FPU_ADDR_OPA;
            fpu_pkg::REG_OPB:    return `FPU_ADDR_OPB;
            fpu_pkg::REG_CTRL:   return `FPU_ADDR_CTRL;
            fpu_pkg::REG_RESULT: return `FPU_ADDR_RESULT;
            fpu_pkg::REG_STATUS: return `FPU_ADDR_STATUS;
            default:             return 5'h14;
        endcase
    endfunction

    function automatic logic [31:0] ctrl_word(input logic go, input fpu_pkg::fp_op_e op);
        logic [31:0] w;
        w = 32'd0;
        w[`FPU_CTRL_GO_BIT] = go;
        w[`FPU_CTRL_OP_BIT] = op;
        return w;
    endfunction

    function automatic logic [31:0] status_word(input logic d, input logic o,
                                                input logic u, input logic n);
        logic [31:0] w;
        w = 32'd0;
        w[`FPU_STAT_DONE_BIT] = d;
        w[`FPU_STAT_OVF_BIT]  = o;
        w[`FPU_STAT_UNF_BIT]  = u;
        w[`FPU_STAT_NAN_BIT]  = n;
        return w;
    endfunction

    // called 2 ns after a rising edge, returns at the same point
    task automatic apb_write(input fpu_pkg::reg_sel_e r, input logic [31:0] data,
                             input logic err);
        exp_err  = err;
        rd_check = 1'b0;
        psel     = 1'b1;
        penable  = 1'b0;
        pwrite   = 1'b1;
        paddr    = reg_addr(r);
        pwdata   = data;
        @(posedge clk);
        #2;
        penable = 1'b1;
        @(posedge clk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
        exp_err = 1'b0;
    endtask

    task automatic apb_read(input fpu_pkg::reg_sel_e r, input logic [31:0] exp,
                            input logic check, input logic err);
        exp_err   = err;
        exp_rdata = exp;
        rd_check  = check;
        psel      = 1'b1;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = reg_addr(r);
        @(posedge clk);
        #2;
        penable = 1'b1;
        @(posedge clk);
        #2;
        psel     = 1'b0;
        penable  = 1'b0;
        rd_check = 1'b0;
        exp_err  = 1'b0;
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            #2;
            n++;
        end while (!uut.done && n < DONE_LIMIT);
        if (!uut.done) begin
            errors++;
            $display("done did not rise within %0d cycles of the go write", DONE_LIMIT);
        end
    endtask

    task automatic run_op(input logic [31:0] a, input logic [31:0] b,
                          input fpu_pkg::fp_op_e op, input logic [31:0] exp_res,
                          input logic [31:0] exp_stat);
        apb_write(fpu_pkg::REG_OPA, a, 1'b0);
        apb_write(fpu_pkg::REG_OPB, b, 1'b0);
        apb_write(fpu_pkg::REG_CTRL, ctrl_word(1'b1, op), 1'b0);
        wait_done();
        apb_read(fpu_pkg::REG_RESULT, exp_res, 1'b1, 1'b0);
        apb_read(fpu_pkg::REG_STATUS, exp_stat, 1'b1, 1'b0);
        last_result = exp_res;
    endtask

    // clears the sticky flags but leaves done alone
    task automatic clear_flags();
        apb_write(fpu_pkg::REG_STATUS, status_word(1'b0, 1'b1, 1'b1, 1'b1), 1'b0);
    endtask

    task automatic begin_test(input string name);
        test_name         = name;
        test_start_errors = errors;
        tests_run++;
    endtask

    task automatic finish_test();
        int n;
        n = errors - test_start_errors;
        if (n == 0) begin
            $display("test %-20s ok", test_name);
        end else begin
            tests_failed++;
            $display("test %-20s %0d errors", test_name, n);
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, simulation stopped", WATCHDOG_NS);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        clk          = 1'b0;
        arst_n       = 1'b0;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = 5'd0;
        pwdata       = 32'd0;
        rd_check     = 1'b0;
        exp_rdata    = 32'd0;
        exp_err      = 1'b0;
        rng_state    = 32'h2af7_302a;
        last_result  = 32'd0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (4) @(posedge clk);
        #2;
        arst_n = 1'b1;
        @(posedge clk);
        #2;

        begin_test("reset_state");
        apb_read(fpu_pkg::REG_STATUS, 32'd0, 1'b1, 1'b0);
        apb_read(fpu_pkg::REG_RESULT, 32'd0, 1'b1, 1'b0);
        finish_test();

        begin_test("arithmetic");
        for (int i = 0; i < 20; i++) begin
            rng_state = xorshift32(rng_state);
            ia        = small_int(rng_state);
            rng_state = xorshift32(rng_state);
            ib        = small_int(rng_state);
            // first pair cancels to +0 on sub
            if (i == 0) begin
                ib = ia;
            end
            ra = shortreal'(ia);
            rb = shortreal'(ib);
            run_op($shortrealtobits(ra), $shortrealtobits(rb), fpu_pkg::FP_ADD,
                   $shortrealtobits(ra + rb), status_word(1'b1, 1'b0, 1'b0, 1'b0));
            run_op($shortrealtobits(ra), $shortrealtobits(rb), fpu_pkg::FP_SUB,
                   $shortrealtobits(ra - rb), status_word(1'b1, 1'b0, 1'b0, 1'b0));
        end
        finish_test();

        begin_test("special_values");
        run_op(32'h7FC0_0000, 32'h3F80_0000, fpu_pkg::FP_ADD, `FPU_QNAN,
               status_word(1'b1, 1'b0, 1'b0, 1'b1));
        clear_flags();
        run_op(32'h3F80_0000, 32'h7F80_0001, fpu_pkg::FP_SUB, `FPU_QNAN,
               status_word(1'b1, 1'b0, 1'b0, 1'b1));
        clear_flags();
        run_op(32'h7F80_0000, 32'h7F80_0000, fpu_pkg::FP_ADD, 32'h7F80_0000,
               status_word(1'b1, 1'b0, 1'b0, 1'b0));
        run_op(32'h7F80_0000, 32'h7F80_0000, fpu_pkg::FP_SUB, `FPU_QNAN,
               status_word(1'b1, 1'b0, 1'b0, 1'b1));
        clear_flags();
        run_op(32'h4049_0FDB, 32'h0000_0000, fpu_pkg::FP_ADD, 32'h4049_0FDB,
               status_word(1'b1, 1'b0, 1'b0, 1'b0));
        // 1.0 is shifted out entirely against 2^30
        run_op(32'h4E80_0000, 32'h3F80_0000, fpu_pkg::FP_ADD, 32'h4E80_0000,
               status_word(1'b1, 1'b0, 1'b0, 1'b0));
        finish_test();

        begin_test("overflow_underflow");
        run_op(32'h7F7F_FFFF, 32'h7F7F_FFFF, fpu_pkg::FP_ADD, 32'h7F80_0000,
               status_word(1'b1, 1'b1, 1'b0, 1'b0));
        // overflow stays sticky while underflow joins it
        run_op(32'h0080_0000, 32'h0040_0000, fpu_pkg::FP_SUB, 32'h0040_0000,
               status_word(1'b1, 1'b1, 1'b1, 1'b0));
        apb_write(fpu_pkg::REG_STATUS, status_word(1'b0, 1'b1, 1'b1, 1'b0), 1'b0);
        apb_read(fpu_pkg::REG_STATUS, status_word(1'b1, 1'b0, 1'b0, 1'b0), 1'b1, 1'b0);
        finish_test();

        begin_test("bus_errors");
        apb_write(fpu_pkg::REG_RESULT, 32'hDEAD_BEEF, 1'b1);
        apb_read(fpu_pkg::REG_RESULT, last_result, 1'b1, 1'b0);
        apb_read(fpu_pkg::REG_NONE, 32'd0, 1'b0, 1'b1);
        apb_write(fpu_pkg::REG_OPA, $shortrealtobits(1.0), 1'b0);
        apb_write(fpu_pkg::REG_OPB, $shortrealtobits(2.0), 1'b0);
        apb_write(fpu_pkg::REG_CTRL, ctrl_word(1'b1, fpu_pkg::FP_ADD), 1'b0);
        // the very next transfer finds the pipeline busy
        apb_write(fpu_pkg::REG_CTRL, ctrl_word(1'b1, fpu_pkg::FP_SUB), 1'b1);
        wait_done();
        apb_read(fpu_pkg::REG_RESULT, $shortrealtobits(3.0), 1'b1, 1'b0);
        apb_read(fpu_pkg::REG_CTRL, ctrl_word(1'b0, fpu_pkg::FP_ADD), 1'b1, 1'b0);
        finish_test();

        repeat (4) @(posedge clk);
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- files.f
+incdir+include
design/fpu_pkg.sv
design/fp_adder_subtractor.sv
design/fpu_exec.sv
design/fpu_apb_regs.sv
design/fpu_apb_top.sv
sim/tb_fpu.sv
